/* sim/tb_cam_top.sv */
`timescale 1ns/1ps

module tb_cam_top;

  import cam_cfg_pkg::*;
  import cam_op_pkg::*;

  localparam int CAM_SIZE     = 64;
  localparam int NUM_BLOCKS   = CAM_SIZE / KEYS_PER_BEAT;
  localparam int RESULT_WIDTH = $clog2(CAM_SIZE) + 1;
  localparam logic [RESULT_WIDTH-1:0] NO_MATCH = '1;
  localparam int CLK_PERIOD   = 8;

  // Stimulus lengths in cycles
  localparam int N_IDLE  = 8;
  localparam int N_PRE   = 4;   // Searches before any load
  localparam int N_FLUSH = 6;   // Drains the search pipeline
  localparam int N_HIT   = 24;
  localparam int N_OLD   = 6;
  localparam int N_NEW   = 8;
  localparam int TOTAL_CYCLES = 3 + N_IDLE + N_PRE + 3 * N_FLUSH + 2 * NUM_BLOCKS
                              + N_HIT + 6 + N_OLD + N_NEW + 1;

  logic                    aclk;
  logic                    areset;
  cam_opcode_e             opcode;
  logic                    s_tvalid;
  logic [BEAT_WIDTH-1:0]   s_tdata;
  logic                    update_all_end;
  logic                    m_tvalid;
  logic [BEAT_WIDTH-1:0]   m_tdata;

  int                      seed = 32'hc4bf;
  int                      load_block;                 // Model of write_block
  logic [KEY_WIDTH-1:0]    mirror       [CAM_SIZE];    // Model of CAM contents
  logic                    mirror_valid [CAM_SIZE];
  logic [KEY_WIDTH-1:0]    load_keys    [CAM_SIZE];    // Next bulk load
  logic [KEY_WIDTH-1:0]    old_keys     [CAM_SIZE];
  logic                    search_hist  [5];           // Slot 0 is now and slot 4 four cycles ago
  logic [RESULT_WIDTH-1:0] exp_q        [$];           // Results in flight
  logic                    exp_valid;
  logic                    exp_done;
  logic [BEAT_WIDTH-1:0]   exp_data;

  cam_top #(
    .CAM_SIZE (CAM_SIZE)
  ) u_dut (
    .aclk           (aclk),
    .areset         (areset),
    .opcode         (opcode),
    .s_tvalid       (s_tvalid),
    .s_tdata        (s_tdata),
    .update_all_end (update_all_end),
    .m_tvalid       (m_tvalid),
    .m_tdata        (m_tdata)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic logic [BEAT_WIDTH-1:0] rand_beat();
    logic [BEAT_WIDTH-1:0] beat;
    for (int k = 0; k < KEYS_PER_BEAT; k++) begin
      beat[k*KEY_WIDTH +: KEY_WIDTH] = $random(seed);
    end
    return beat;
  endfunction

  // Lowest valid entry equal to the key
  function automatic logic [RESULT_WIDTH-1:0] lowest_match(input logic [KEY_WIDTH-1:0] key);
    for (int i = 0; i < CAM_SIZE; i++) begin
      if (mirror_valid[i] && mirror[i] == key) begin
        return RESULT_WIDTH'(i);
      end
    end
    return NO_MATCH;
  endfunction

  // One cycle of stimulus plus the expected output for that cycle
  task automatic drive_beat(input cam_opcode_e op, input logic vld,
                            input logic [BEAT_WIDTH-1:0] data);
    @(negedge aclk);
    opcode   = op;
    s_tvalid = vld;
    s_tdata  = data;
    for (int i = 4; i > 0; i--) begin
      search_hist[i] = search_hist[i-1];
    end
    search_hist[0] = vld && (op == OP_SEARCH);
    exp_done = 1'b0;
    if (vld && op == OP_LOAD_ALL) begin
      for (int k = 0; k < KEYS_PER_BEAT; k++) begin
        mirror[load_block*KEYS_PER_BEAT + k]       = data[k*KEY_WIDTH +: KEY_WIDTH];
        mirror_valid[load_block*KEYS_PER_BEAT + k] = 1'b1;
      end
      if (load_block == NUM_BLOCKS - 1) begin
        exp_done   = 1'b1;
        load_block = 0;  // Counter wraps
      end else begin
        load_block++;
      end
    end
    if (search_hist[0]) begin
      exp_q.push_back(lowest_match(data[KEY_WIDTH-1:0]));
    end
    if (exp_done) begin
      exp_valid = 1'b1;
      exp_data  = BEAT_WIDTH'(LOAD_DONE_CODE);
      if (search_hist[4]) begin
        void'(exp_q.pop_front());  // Lost to load-done
      end
    end else if (search_hist[4]) begin
      exp_valid = 1'b1;
      exp_data  = BEAT_WIDTH'(exp_q.pop_front());
    end else begin
      exp_valid = 1'b0;
      exp_data  = '0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_beat(OP_IDLE, 1'b0, rand_beat());
  endtask

  task automatic search_for(input logic [KEY_WIDTH-1:0] key);
    logic [BEAT_WIDTH-1:0] beat;
    beat = rand_beat();
    beat[KEY_WIDTH-1:0] = key;  // Key rides in lane 0
    drive_beat(OP_SEARCH, 1'b1, beat);
  endtask

  // Bulk load of load_keys with one block per beat
  task automatic load_all();
    logic [BEAT_WIDTH-1:0] beat;
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      for (int k = 0; k < KEYS_PER_BEAT; k++) begin
        beat[k*KEY_WIDTH +: KEY_WIDTH] = load_keys[b*KEYS_PER_BEAT + k];
      end
      drive_beat(OP_LOAD_ALL, 1'b1, beat);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks against the model sampled on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  a_tvalid: assert property (@(posedge aclk) disable iff (areset) m_tvalid == exp_valid)
    else report_failure($sformatf("m_tvalid wrong, expected %0b", exp_valid));

  a_load_end: assert property (@(posedge aclk) disable iff (areset) update_all_end == exp_done)
    else report_failure($sformatf("update_all_end wrong, expected %0b", exp_done));

  a_tdata: assert property (@(posedge aclk) disable iff (areset) m_tdata == exp_data)
    else report_failure($sformatf("m_tdata wrong, expected 0x%0h", exp_data[31:0]));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    areset     = 1'b1;
    opcode     = OP_IDLE;
    s_tvalid   = 1'b0;
    s_tdata    = '0;
    load_block = 0;
    exp_valid  = 1'b0;
    exp_done   = 1'b0;
    exp_data   = '0;
    for (int i = 0; i < 5; i++) begin
      search_hist[i] = 1'b0;
    end
    for (int i = 0; i < CAM_SIZE; i++) begin
      mirror[i]       = '0;
      mirror_valid[i] = 1'b0;  // Nothing loaded yet
    end
    repeat (3) @(negedge aclk);
    areset = 1'b0;

    // Idle opcode or valid low with a real opcode
    for (int i = 0; i < N_IDLE; i++) begin
      case (i % 3)
        0:       drive_beat(OP_IDLE, 1'b1, rand_beat());
        1:       drive_beat(OP_SEARCH, 1'b0, rand_beat());
        default: drive_beat(OP_LOAD_ALL, 1'b0, rand_beat());
      endcase
    end

    repeat (N_PRE) search_for($random(seed));  // Empty CAM so every search misses
    idle_cycles(N_FLUSH);

    for (int i = 0; i < CAM_SIZE; i++) begin
      load_keys[i] = $random(seed);
    end
    load_keys[40] = load_keys[5];   // Pair across segments
    load_keys[20] = load_keys[10];  // Pair inside segment 0
    load_all();

    // Back-to-back hits
    repeat (N_HIT) search_for(load_keys[{$random(seed)} % CAM_SIZE]);
    search_for(load_keys[40]);
    search_for(load_keys[20]);
    search_for(load_keys[5]);
    search_for(load_keys[10]);
    search_for(32'hdead_beef);  // Most likely absent
    search_for(~load_keys[0]);
    idle_cycles(N_FLUSH);

    // Overwrite with fresh keys
    for (int i = 0; i < CAM_SIZE; i++) begin
      old_keys[i]  = load_keys[i];
      load_keys[i] = $random(seed);
    end
    load_all();
    for (int i = 0; i < N_OLD; i++) begin
      search_for(old_keys[i * 7]);
    end
    for (int i = 0; i < N_NEW; i++) begin
      search_for(load_keys[i * 8 + 3]);
    end
    idle_cycles(N_FLUSH);
    @(posedge aclk);
    #1;

    $display("=== PASS ===");
    $finish;
  end

  // Watchdog
  initial begin
    #(4 * TOTAL_CYCLES * CLK_PERIOD);
    $display("The run timed out after %0t ns without finishing the tests", $time);
    $display("=== FAIL ===");
    $fatal(1, "Timeout");
  end

endmodule : tb_cam_top

/* source/cam_cell.sv */
`timescale 1ns/1ps

module cam_cell #(
  parameter int CAM_SIZE    = 64,
  parameter int ENTRY_INDEX = 0   // Position of this entry in the CAM
) (
  input  logic                                             aclk,
  input  logic                                             areset,
  input  logic                                             load_fire,
  input  logic [$clog2(CAM_SIZE/cam_cfg_pkg::KEYS_PER_BEAT)-1:0] write_block,
  input  logic [cam_cfg_pkg::BEAT_WIDTH-1:0]               s_tdata,
  input  logic [cam_cfg_pkg::KEY_WIDTH-1:0]                search_key,
  output logic                                             match
);

  import cam_cfg_pkg::*;

  localparam int BLOCK_WIDTH = $clog2(CAM_SIZE / KEYS_PER_BEAT);
  localparam int MY_BLOCK    = ENTRY_INDEX / KEYS_PER_BEAT;  // Beat that writes us
  localparam int MY_LANE     = ENTRY_INDEX % KEYS_PER_BEAT;  // Lane within that beat

  logic [KEY_WIDTH-1:0] entry;        // Stored key
  logic                 entry_valid;  // Loaded since reset
  logic                 write_en;

  assign write_en = load_fire && (write_block == BLOCK_WIDTH'(MY_BLOCK));

  // Entry storage
  always_ff @(posedge aclk) begin
    if (write_en) begin
      entry <= s_tdata[MY_LANE*KEY_WIDTH +: KEY_WIDTH];
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      entry_valid <= 1'b0;
    end else if (write_en) begin
      entry_valid <= 1'b1;  // Sticky until next reset
    end
  end

  // Search stage 2: XOR compare, zero means hit
  always_ff @(posedge aclk) begin
    if (areset) begin
      match <= 1'b0;
    end else begin
      match <= entry_valid && !(|(entry ^ search_key));
    end
  end

endmodule : cam_cell

/* source/cam_cfg_pkg.sv */
package cam_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data-path sizes
  ////////////////////////////////////////////////////////////////////////////

  // One CAM entry / one search key
  parameter int KEY_WIDTH = 32;

  // Keys packed in one stream beat
  parameter int KEYS_PER_BEAT = 16;

  // Stream data width, in and out
  parameter int BEAT_WIDTH = KEY_WIDTH * KEYS_PER_BEAT;

  ////////////////////////////////////////////////////////////////////////////
  // Output codes
  ////////////////////////////////////////////////////////////////////////////

  // Put on m_tdata in the cycle a bulk load completes
  parameter logic [31:0] LOAD_DONE_CODE = 32'd100;

endpackage : cam_cfg_pkg

/* source/cam_loader.sv */
`timescale 1ns/1ps

module cam_loader #(
  parameter int CAM_SIZE = 64  // Entries, multiple of KEYS_PER_BEAT
) (
  input  logic                                             aclk,
  input  logic                                             areset,
  input  cam_op_pkg::cam_opcode_e                          opcode,
  input  logic                                             s_tvalid,
  input  logic [cam_cfg_pkg::BEAT_WIDTH-1:0]               s_tdata,
  output logic                                             load_fire,
  output logic                                             load_done,
  output logic                                             key_valid,
  output logic [$clog2(CAM_SIZE/cam_cfg_pkg::KEYS_PER_BEAT)-1:0] write_block,
  output logic [cam_cfg_pkg::KEY_WIDTH-1:0]                search_key
);

  import cam_cfg_pkg::*;
  import cam_op_pkg::*;

  localparam int NUM_BLOCKS  = CAM_SIZE / KEYS_PER_BEAT;  // Beats per full load
  localparam int BLOCK_WIDTH = $clog2(NUM_BLOCKS);

  logic search_fire;  // Search beat accepted this cycle

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////

  // Always ready, so a beat is taken whenever valid is up
  assign load_fire   = s_tvalid && (opcode == OP_LOAD_ALL);
  assign search_fire = s_tvalid && (opcode == OP_SEARCH);

  // Last block of the load; zero latency to the output stream
  assign load_done = load_fire && (write_block == BLOCK_WIDTH'(NUM_BLOCKS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Load block counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      write_block <= '0;
    end else if (load_fire) begin
      if (load_done) begin
        write_block <= '0;  // Wrap for the next bulk load
      end else begin
        write_block <= write_block + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Search stage 1: key register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      key_valid <= 1'b0;
    end else begin
      key_valid <= search_fire;  // Marks T+1
    end
  end

  // Only lane 0 carries the search key
  always_ff @(posedge aclk) begin
    if (search_fire) begin
      search_key <= s_tdata[KEY_WIDTH-1:0];
    end
  end

endmodule : cam_loader

/* source/cam_match_encoder.sv */
`timescale 1ns/1ps

module cam_match_encoder #(
  parameter int CAM_SIZE = 64,
  parameter int SEGMENTS = 2    // Must divide CAM_SIZE
) (
  input  logic                               aclk,
  input  logic                               areset,
  input  logic [CAM_SIZE-1:0]                match,
  input  logic                               key_valid,
  input  logic                               load_done,
  output logic                               m_tvalid,
  output logic [cam_cfg_pkg::BEAT_WIDTH-1:0] m_tdata
);

  import cam_cfg_pkg::*;

  localparam int INDEX_WIDTH = $clog2(CAM_SIZE);
  localparam int RESULT_WIDTH = INDEX_WIDTH + 1;        // Extra bit for no-match
  localparam logic [RESULT_WIDTH-1:0] NO_MATCH = '1;
  localparam int SEG_SIZE = CAM_SIZE / SEGMENTS;        // Entries per segment

  logic                    match_valid;   // Stage 2 valid
  logic                    seg_valid;     // Stage 3 valid
  logic                    result_valid;  // Stage 4 valid

  logic [RESULT_WIDTH-1:0] seg_next  [SEGMENTS];  // Lowest hit per segment, comb
  logic [RESULT_WIDTH-1:0] seg_index [SEGMENTS];  // Same, registered
  logic [RESULT_WIDTH-1:0] final_next;
  logic [RESULT_WIDTH-1:0] final_index;

  ////////////////////////////////////////////////////////////////////////////
  // Valid pipeline, follows the data through stages 2..4
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      match_valid  <= 1'b0;
      seg_valid    <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      match_valid  <= key_valid;    // T+2
      seg_valid    <= match_valid;  // T+3
      result_valid <= seg_valid;    // T+4
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 3: per-segment priority encode
  ////////////////////////////////////////////////////////////////////////////

  // Scan from the top down so the lowest hit is written last
  always_comb begin
    for (int s = 0; s < SEGMENTS; s++) begin
      seg_next[s] = NO_MATCH;
      for (int i = SEG_SIZE - 1; i >= 0; i--) begin
        if (match[s*SEG_SIZE + i]) begin
          seg_next[s] = RESULT_WIDTH'(s*SEG_SIZE + i);
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    seg_index <= seg_next;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 4: pick first segment with a hit
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    final_next = NO_MATCH;
    for (int s = SEGMENTS - 1; s >= 0; s--) begin
      if (seg_index[s] != NO_MATCH) begin
        final_next = seg_index[s];
      end
    end
  end

  always_ff @(posedge aclk) begin
    final_index <= final_next;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stream mux
  ////////////////////////////////////////////////////////////////////////////

  // Load-done wins a collision; the search result that cycle is dropped
  always_comb begin
    if (load_done) begin
      m_tvalid = 1'b1;
      m_tdata  = BEAT_WIDTH'(LOAD_DONE_CODE);
    end else if (result_valid) begin
      m_tvalid = 1'b1;
      m_tdata  = BEAT_WIDTH'(final_index);  // Zero-extended index or NO_MATCH
    end else begin
      m_tvalid = 1'b0;
      m_tdata  = '0;
    end
  end

endmodule : cam_match_encoder

/* source/cam_op_pkg.sv */
package cam_op_pkg;

  // Operation requested by the host for the current beat.
  typedef enum logic [2:0] {
    OP_IDLE     = 3'd0,  // Nothing to do
    OP_LOAD_ALL = 3'd1,  // Bulk load of 16 entries per beat
    OP_SEARCH   = 3'd2   // One key per beat in the low lane
  } cam_opcode_e;

endpackage : cam_op_pkg

/* source/cam_top.sv */
`timescale 1ns/1ps

module cam_top #(
  parameter int CAM_SIZE = 64,  // Multiple of KEYS_PER_BEAT
  parameter int SEGMENTS = 2    // Encoder segments, divides CAM_SIZE
) (
  input  logic                               aclk,
  input  logic                               areset,
  input  cam_op_pkg::cam_opcode_e            opcode,
  input  logic                               s_tvalid,
  input  logic [cam_cfg_pkg::BEAT_WIDTH-1:0] s_tdata,
  output logic                               update_all_end,
  output logic                               m_tvalid,
  output logic [cam_cfg_pkg::BEAT_WIDTH-1:0] m_tdata
);

  import cam_cfg_pkg::*;

  localparam int BLOCK_WIDTH = $clog2(CAM_SIZE / KEYS_PER_BEAT);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  logic                   load_fire;    // Load beat taken
  logic [BLOCK_WIDTH-1:0] write_block;  // Current group of 16 entries
  logic                   key_valid;    // Stage 1 valid
  logic [KEY_WIDTH-1:0]   search_key;   // Stage 1 key
  logic [CAM_SIZE-1:0]    match;        // Stage 2 hit vector

  ////////////////////////////////////////////////////////////////////////////
  // Loader
  ////////////////////////////////////////////////////////////////////////////

  // Load-done goes straight out as update_all_end
  cam_loader #(
    .CAM_SIZE    (CAM_SIZE)
  ) u_loader (
    .aclk        (aclk),
    .areset      (areset),
    .opcode      (opcode),
    .s_tvalid    (s_tvalid),
    .s_tdata     (s_tdata),
    .load_fire   (load_fire),
    .load_done   (update_all_end),
    .key_valid   (key_valid),
    .write_block (write_block),
    .search_key  (search_key)
  );

  // One cell per entry
  for (genvar i = 0; i < CAM_SIZE; i++) begin : gen_cell
    cam_cell #(
      .CAM_SIZE    (CAM_SIZE),
      .ENTRY_INDEX (i)
    ) u_cell (
      .aclk        (aclk),
      .areset      (areset),
      .load_fire   (load_fire),
      .write_block (write_block),
      .s_tdata     (s_tdata),
      .search_key  (search_key),
      .match       (match[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Match encoder and output stream
  ////////////////////////////////////////////////////////////////////////////

  cam_match_encoder #(
    .CAM_SIZE  (CAM_SIZE),
    .SEGMENTS  (SEGMENTS)
  ) u_encoder (
    .aclk      (aclk),
    .areset    (areset),
    .match     (match),
    .key_valid (key_valid),
    .load_done (update_all_end),
    .m_tvalid  (m_tvalid),
    .m_tdata   (m_tdata)
  );

endmodule : cam_top

/* verilog.f */
source/cam_cfg_pkg.sv
source/cam_op_pkg.sv
source/cam_loader.sv
source/cam_cell.sv
source/cam_match_encoder.sv
source/cam_top.sv
sim/tb_cam_top.sv
